// File: lsq.f
rtl/lsq_pkg.sv
rtl/lsq_entry.sv
rtl/lsq_store_scan.sv
rtl/lsq_ptrs.sv
rtl/lsq_port_arb.sv
rtl/lsq_top.sv
testbench/lsq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the LSQ testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module lsq_tb -f lsq.f -o lsq_sim \
    && ./obj_dir/lsq_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0

// File: testbench/lsq_tb.sv
// LSQ directed testbench
`timescale 1ns/1ps

module lsq_tb;

    localparam int LSQ_DEPTH      = 4;
    // Five tests of at most about 200 cycles each plus a wide margin
    localparam int TIMEOUT_CYCLES = 3000;
    // Longest wait for one broadcast or one write
    localparam int WAIT_LIMIT     = 50;

    logic               clk_i;
    logic               arst_n_i;
    logic               dp_valid_i;
    lsq_pkg::lsq_cmd_e  dp_cmd_i;
    lsq_pkg::mem_size_e dp_size_i;
    logic               dp_sign_i;
    lsq_pkg::rob_idx_t  dp_rob_idx_i;
    lsq_pkg::tag_t      dp_tag_i;
    logic               fu_valid_i;
    lsq_pkg::rob_idx_t  fu_rob_idx_i;
    lsq_pkg::word_t     fu_addr_i;
    lsq_pkg::word_t     fu_data_i;
    logic               mem_req_o;
    logic               mem_we_o;
    lsq_pkg::word_t     mem_addr_o;
    lsq_pkg::mem_size_e mem_size_o;
    lsq_pkg::word_t     mem_wdata_o;
    logic               mem_ack_i;
    lsq_pkg::word_t     mem_rdata_i;
    logic               bc_valid_o;
    lsq_pkg::tag_t      bc_tag_o;
    lsq_pkg::rob_idx_t  bc_rob_idx_o;
    lsq_pkg::word_t     bc_data_o;
    logic               bc_done_i;
    logic               rt_valid_i;
    lsq_pkg::rob_idx_t  rt_rob_idx_i;
    logic               rollback_i;
    logic               full_o;

    // Memory contents and access log
    lsq_pkg::word_t     mem_model [lsq_pkg::word_t];
    logic               log_we [$];
    lsq_pkg::word_t     log_addr [$];
    lsq_pkg::word_t     log_data [$];
    lsq_pkg::mem_size_e log_size [$];
    int                 errors    = 0;
    int                 checks    = 0;
    int                 cycle_cnt = 0;

    lsq_top #(.LSQ_DEPTH(LSQ_DEPTH)) u_lsq_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ==============================
    // Memory model
    // ==============================

    // Unwritten words read as the inverted address
    function automatic lsq_pkg::word_t mem_read(input lsq_pkg::word_t addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return ~addr;
    endfunction

    // Every request is acknowledged in the same cycle
    assign mem_ack_i   = mem_req_o;
    assign mem_rdata_i = mem_read(mem_addr_o);

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (mem_req_o && mem_ack_i) begin
            log_we.push_back(mem_we_o);
            log_addr.push_back(mem_addr_o);
            log_data.push_back(mem_we_o ? mem_wdata_o : mem_rdata_i);
            log_size.push_back(mem_size_o);
            if (mem_we_o) begin
                mem_model[mem_addr_o] = mem_wdata_o;
            end
            $display("%0t mem %s addr %h data %h", $time, mem_we_o ? "wr" : "rd",
                     mem_addr_o, mem_we_o ? mem_wdata_o : mem_rdata_i);
        end
    end

    // ==============================
    // Helpers
    // ==============================

    // Keep the low nbits and extend them to 32 bits
    function automatic lsq_pkg::word_t sized_value(input lsq_pkg::word_t raw, input int nbits,
                                                   input logic signed_ext);
        lsq_pkg::word_t shifted;
        int             sh;
        sh      = 32 - nbits;
        shifted = raw << sh;
        if (signed_ext) begin
            return lsq_pkg::word_t'($signed(shifted) >>> sh);
        end
        return shifted >> sh;
    endfunction

    function automatic int count_accesses(input logic we);
        int n;
        n = 0;
        foreach (log_we[i]) begin
            if (log_we[i] == we) n++;
        end
        return n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_log();
        log_we.delete();
        log_addr.delete();
        log_data.delete();
        log_size.delete();
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk_i);
    endtask

    task automatic dispatch(input lsq_pkg::lsq_cmd_e cmd, input lsq_pkg::mem_size_e size,
                            input logic sign, input lsq_pkg::rob_idx_t rob,
                            input lsq_pkg::tag_t tag);
        @(negedge clk_i);
        dp_valid_i   = 1'b1;
        dp_cmd_i     = cmd;
        dp_size_i    = size;
        dp_sign_i    = sign;
        dp_rob_idx_i = rob;
        dp_tag_i     = tag;
        @(negedge clk_i);
        dp_valid_i   = 1'b0;
    endtask

    task automatic fu_result(input lsq_pkg::rob_idx_t rob, input lsq_pkg::word_t addr,
                             input lsq_pkg::word_t data);
        @(negedge clk_i);
        fu_valid_i   = 1'b1;
        fu_rob_idx_i = rob;
        fu_addr_i    = addr;
        fu_data_i    = data;
        @(negedge clk_i);
        fu_valid_i   = 1'b0;
    endtask

    task automatic retire(input lsq_pkg::rob_idx_t rob);
        @(negedge clk_i);
        rt_valid_i   = 1'b1;
        rt_rob_idx_i = rob;
        @(negedge clk_i);
        rt_valid_i   = 1'b0;
    endtask

    task automatic pulse_rollback();
        @(negedge clk_i);
        rollback_i = 1'b1;
        @(negedge clk_i);
        rollback_i = 1'b0;
    endtask

    task automatic wait_bc_valid(output logic seen);
        int n;
        n = 0;
        while (!bc_valid_o && (n < WAIT_LIMIT)) begin
            @(negedge clk_i);
            n++;
        end
        seen = bc_valid_o;
        if (!seen) begin
            errors++;
            $display("No broadcast appeared within %0d cycles at %0t", WAIT_LIMIT, $time);
        end
    endtask

    task automatic wait_writes(input int count);
        int n;
        n = 0;
        while ((count_accesses(1'b1) < count) && (n < WAIT_LIMIT)) begin
            @(negedge clk_i);
            n++;
        end
        if (count_accesses(1'b1) < count) begin
            errors++;
            $display("Store write missing after %0d cycles at %0t", WAIT_LIMIT, $time);
        end
    endtask

    // Check the broadcast fields and accept it with a one-cycle bc_done_i
    task automatic take_broadcast(input string what, input lsq_pkg::tag_t tag,
                                  input lsq_pkg::rob_idx_t rob, input lsq_pkg::word_t data);
        logic seen;
        wait_bc_valid(seen);
        if (seen) begin
            check_value({what, " bc_data"}, bc_data_o, data);
            check_value({what, " bc_tag"}, bc_tag_o, tag);
            check_value({what, " bc_rob_idx"}, bc_rob_idx_o, rob);
            bc_done_i = 1'b1;
            @(negedge clk_i);
            bc_done_i = 1'b0;
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic test_store_path();
        lsq_pkg::word_t data;
        data = $urandom();
        clear_log();
        dispatch(lsq_pkg::STORE, lsq_pkg::WORD, 1'b0, 5'd1, 6'd1);
        fu_result(5'd1, 32'h0000_0100, data);
        idle(4);
        // No write may happen before the ROB retires the store
        check_value("writes before retire", count_accesses(1'b1), 0);
        retire(5'd1);
        wait_writes(1);
        check_value("store write count", log_we.size(), 1);
        if (log_we.size() == 1) begin
            check_value("store addr", log_addr[0], 32'h0000_0100);
            check_value("store data", log_data[0], data);
            check_value("store size", log_size[0], lsq_pkg::WORD);
        end
        check_value("full_o in store test", full_o, 1'b0);
        idle(3);
    endtask

    task automatic test_load_memory();
        clear_log();
        // Two loads in flight and served oldest first
        dispatch(lsq_pkg::LOAD, lsq_pkg::BYTE, 1'b1, 5'd2, 6'd5);
        dispatch(lsq_pkg::LOAD, lsq_pkg::HALF, 1'b0, 5'd3, 6'd6);
        fu_result(5'd2, 32'h0000_2004, '0);
        fu_result(5'd3, 32'h0000_3000, '0);
        take_broadcast("signed byte", 6'd5, 5'd2, sized_value(mem_read(32'h0000_2004), 8, 1'b1));
        take_broadcast("unsigned half", 6'd6, 5'd3,
                       sized_value(mem_read(32'h0000_3000), 16, 1'b0));
        retire(5'd2);
        retire(5'd3);
        check_value("memory reads for two loads", count_accesses(1'b0), 2);
        idle(3);
    endtask

    task automatic test_forwarding();
        lsq_pkg::word_t data;
        // Negative half so that sign extension shows
        data = $urandom() | 32'h0000_8000;
        clear_log();
        dispatch(lsq_pkg::STORE, lsq_pkg::HALF, 1'b0, 5'd4, 6'd0);
        dispatch(lsq_pkg::LOAD, lsq_pkg::HALF, 1'b1, 5'd5, 6'd7);
        fu_result(5'd4, 32'h0000_4000, data);
        fu_result(5'd5, 32'h0000_4000, '0);
        take_broadcast("forwarded half", 6'd7, 5'd5, sized_value(data, 16, 1'b1));
        check_value("reads during forwarding", count_accesses(1'b0), 0);
        retire(5'd4);
        retire(5'd5);
        wait_writes(1);
        idle(4);
    endtask

    task automatic test_unknown_store();
        clear_log();
        dispatch(lsq_pkg::STORE, lsq_pkg::WORD, 1'b0, 5'd6, 6'd0);
        dispatch(lsq_pkg::LOAD, lsq_pkg::WORD, 1'b0, 5'd7, 6'd9);
        fu_result(5'd7, 32'h0000_5000, '0);
        idle(5);
        // Load must hold while the older store address is unknown
        check_value("reads while store address unknown", count_accesses(1'b0), 0);
        check_value("bc_valid_o while store address unknown", bc_valid_o, 1'b0);
        fu_result(5'd6, 32'h0000_6000, 32'h1234_5678);
        take_broadcast("load after store address", 6'd9, 5'd7,
                       sized_value(mem_read(32'h0000_5000), 32, 1'b0));
        check_value("reads after store address", count_accesses(1'b0), 1);
        retire(5'd6);
        retire(5'd7);
        idle(5);
    endtask

    task automatic test_full_rollback();
        logic seen;
        clear_log();
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            dispatch(lsq_pkg::LOAD, lsq_pkg::WORD, 1'b0, lsq_pkg::rob_idx_t'(8 + i),
                     lsq_pkg::tag_t'(8 + i));
        end
        check_value("full_o after four dispatches", full_o, 1'b1);
        // Dropped because the queue is full
        dispatch(lsq_pkg::LOAD, lsq_pkg::WORD, 1'b0, 5'd12, 6'd12);
        fu_result(5'd8, 32'h0000_7000, '0);
        wait_bc_valid(seen);
        fu_result(5'd12, 32'h0000_7100, '0);
        idle(3);
        check_value("reads with dropped dispatch", count_accesses(1'b0), 1);
        check_value("full_o while full", full_o, 1'b1);
        check_value("bc_valid_o held without bc_done_i", bc_valid_o, 1'b1);
        // The oldest load keeps the broadcast port
        if (seen) begin
            check_value("held bc_rob_idx", bc_rob_idx_o, 5'd8);
        end
        pulse_rollback();
        check_value("full_o after rollback", full_o, 1'b0);
        check_value("bc_valid_o after rollback", bc_valid_o, 1'b0);
        check_value("mem_req_o after rollback", mem_req_o, 1'b0);
        dispatch(lsq_pkg::LOAD, lsq_pkg::HALF, 1'b1, 5'd13, 6'd13);
        fu_result(5'd13, 32'h0000_7204, '0);
        take_broadcast("load after rollback", 6'd13, 5'd13,
                       sized_value(mem_read(32'h0000_7204), 16, 1'b1));
        retire(5'd13);
        idle(3);
    endtask

    // ==============================
    // Run control
    // ==============================
    initial begin
        void'($urandom(41303));
        arst_n_i     = 1'b0;
        dp_valid_i   = 1'b0;
        dp_cmd_i     = lsq_pkg::NONE;
        dp_size_i    = lsq_pkg::BYTE;
        dp_sign_i    = 1'b0;
        dp_rob_idx_i = '0;
        dp_tag_i     = '0;
        fu_valid_i   = 1'b0;
        fu_rob_idx_i = '0;
        fu_addr_i    = '0;
        fu_data_i    = '0;
        bc_done_i    = 1'b0;
        rt_valid_i   = 1'b0;
        rt_rob_idx_i = '0;
        rollback_i   = 1'b0;
        repeat (5) @(negedge clk_i);
        arst_n_i = 1'b1;
        test_store_path();
        test_load_memory();
        test_forwarding();
        test_unknown_store();
        test_full_rollback();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog on the cycle counter
    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: rtl/lsq_top.sv
// LSQ top level
`timescale 1ns/1ps

module lsq_top #(
    parameter int  LSQ_DEPTH = 4,
    localparam int IDX_W     = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // Dispatch
    input  logic               dp_valid_i,
    input  lsq_pkg::lsq_cmd_e  dp_cmd_i,
    input  lsq_pkg::mem_size_e dp_size_i,
    input  logic               dp_sign_i,
    input  lsq_pkg::rob_idx_t  dp_rob_idx_i,
    input  lsq_pkg::tag_t      dp_tag_i,
    // Functional unit
    input  logic               fu_valid_i,
    input  lsq_pkg::rob_idx_t  fu_rob_idx_i,
    input  lsq_pkg::word_t     fu_addr_i,
    input  lsq_pkg::word_t     fu_data_i,
    // Memory
    output logic               mem_req_o,
    output logic               mem_we_o,
    output lsq_pkg::word_t     mem_addr_o,
    output lsq_pkg::mem_size_e mem_size_o,
    output lsq_pkg::word_t     mem_wdata_o,
    input  logic               mem_ack_i,
    input  lsq_pkg::word_t     mem_rdata_i,
    // Broadcast
    output logic               bc_valid_o,
    output lsq_pkg::tag_t      bc_tag_o,
    output lsq_pkg::rob_idx_t  bc_rob_idx_o,
    output lsq_pkg::word_t     bc_data_o,
    input  logic               bc_done_i,
    // ROB retire and control
    input  logic               rt_valid_i,
    input  lsq_pkg::rob_idx_t  rt_rob_idx_i,
    input  logic               rollback_i,
    output logic               full_o
);

    logic [IDX_W-1:0]                          head;
    logic                                      head_retire;
    logic                [LSQ_DEPTH-1:0]       alloc;
    logic                [LSQ_DEPTH-1:0]       free;
    logic                [LSQ_DEPTH-1:0]       mem_grant;
    logic                [LSQ_DEPTH-1:0]       bc_grant;
    // Entry contents
    lsq_pkg::lsq_state_e [LSQ_DEPTH-1:0]       ent_state;
    lsq_pkg::lsq_cmd_e   [LSQ_DEPTH-1:0]       ent_cmd;
    lsq_pkg::mem_size_e  [LSQ_DEPTH-1:0]       ent_size;
    lsq_pkg::word_t      [LSQ_DEPTH-1:0]       ent_addr;
    logic                [LSQ_DEPTH-1:0]       ent_addr_valid;
    lsq_pkg::word_t      [LSQ_DEPTH-1:0]       ent_data;
    lsq_pkg::rob_idx_t   [LSQ_DEPTH-1:0]       ent_rob_idx;
    lsq_pkg::tag_t       [LSQ_DEPTH-1:0]       ent_tag;
    // Scan results per entry
    logic                [LSQ_DEPTH-1:0]       older_known;
    logic                [LSQ_DEPTH-1:0]       depend;
    lsq_pkg::word_t      [LSQ_DEPTH-1:0]       fwd_data;

    // Head entry done and ready to leave
    assign head_retire = (ent_state[head] == lsq_pkg::RETIRE);

    lsq_ptrs #(.LSQ_DEPTH(LSQ_DEPTH)) u_ptrs (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .rollback_i(rollback_i),
        .dp_valid_i(dp_valid_i), .head_retire_i(head_retire),
        .head_o(head), .alloc_o(alloc), .free_o(free), .full_o(full_o)
    );

    // ==============================
    // Entries and their store scans
    // ==============================
    for (genvar i = 0; i < LSQ_DEPTH; i++) begin : g_entry
        lsq_entry #(.LSQ_DEPTH(LSQ_DEPTH)) u_entry (
            .clk_i(clk_i), .arst_n_i(arst_n_i), .rollback_i(rollback_i),
            .alloc_i(alloc[i]), .free_i(free[i]),
            .dp_cmd_i(dp_cmd_i), .dp_size_i(dp_size_i), .dp_sign_i(dp_sign_i),
            .dp_rob_idx_i(dp_rob_idx_i), .dp_tag_i(dp_tag_i),
            .fu_valid_i(fu_valid_i), .fu_rob_idx_i(fu_rob_idx_i),
            .fu_addr_i(fu_addr_i), .fu_data_i(fu_data_i),
            .older_known_i(older_known[i]), .depend_i(depend[i]), .fwd_data_i(fwd_data[i]),
            .mem_grant_i(mem_grant[i]), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
            .bc_grant_i(bc_grant[i]), .bc_done_i(bc_done_i),
            .rt_valid_i(rt_valid_i), .rt_rob_idx_i(rt_rob_idx_i),
            .state_o(ent_state[i]), .cmd_o(ent_cmd[i]), .size_o(ent_size[i]),
            .addr_o(ent_addr[i]), .addr_valid_o(ent_addr_valid[i]), .data_o(ent_data[i]),
            .rob_idx_o(ent_rob_idx[i]), .tag_o(ent_tag[i])
        );

        lsq_store_scan #(.LSQ_DEPTH(LSQ_DEPTH), .ENTRY_IDX(i)) u_scan (
            .head_i(head), .cmd_i(ent_cmd), .addr_valid_i(ent_addr_valid),
            .addr_i(ent_addr), .size_i(ent_size), .data_i(ent_data),
            .own_addr_i(ent_addr[i]), .own_size_i(ent_size[i]),
            .older_known_o(older_known[i]), .depend_o(depend[i]), .fwd_data_o(fwd_data[i])
        );
    end

    lsq_port_arb #(.LSQ_DEPTH(LSQ_DEPTH)) u_arb (
        .head_i(head), .state_i(ent_state), .cmd_i(ent_cmd), .addr_i(ent_addr),
        .size_i(ent_size), .data_i(ent_data), .tag_i(ent_tag), .rob_idx_i(ent_rob_idx),
        .mem_grant_o(mem_grant), .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_size_o(mem_size_o), .mem_wdata_o(mem_wdata_o),
        .bc_grant_o(bc_grant), .bc_valid_o(bc_valid_o), .bc_tag_o(bc_tag_o),
        .bc_rob_idx_o(bc_rob_idx_o), .bc_data_o(bc_data_o)
    );

endmodule

// File: rtl/lsq_port_arb.sv
// LSQ memory and broadcast arbiter
`timescale 1ns/1ps

module lsq_port_arb #(
    parameter int  LSQ_DEPTH = 4,
    localparam int IDX_W     = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1
) (
    input  logic [IDX_W-1:0]                      head_i,
    // Fields of all entries
    input  lsq_pkg::lsq_state_e [LSQ_DEPTH-1:0]   state_i,
    input  lsq_pkg::lsq_cmd_e   [LSQ_DEPTH-1:0]   cmd_i,
    input  lsq_pkg::word_t      [LSQ_DEPTH-1:0]   addr_i,
    input  lsq_pkg::mem_size_e  [LSQ_DEPTH-1:0]   size_i,
    input  lsq_pkg::word_t      [LSQ_DEPTH-1:0]   data_i,
    input  lsq_pkg::tag_t       [LSQ_DEPTH-1:0]   tag_i,
    input  lsq_pkg::rob_idx_t   [LSQ_DEPTH-1:0]   rob_idx_i,
    // Memory port
    output logic                [LSQ_DEPTH-1:0]   mem_grant_o,
    output logic                                  mem_req_o,
    output logic                                  mem_we_o,
    output lsq_pkg::word_t                        mem_addr_o,
    output lsq_pkg::mem_size_e                    mem_size_o,
    output lsq_pkg::word_t                        mem_wdata_o,
    // Broadcast port
    output logic                [LSQ_DEPTH-1:0]   bc_grant_o,
    output logic                                  bc_valid_o,
    output lsq_pkg::tag_t                         bc_tag_o,
    output lsq_pkg::rob_idx_t                     bc_rob_idx_o,
    output lsq_pkg::word_t                        bc_data_o
);

    logic [IDX_W-1:0] mem_sel;
    logic [IDX_W-1:0] bc_sel;

    // ==============================
    // Oldest-first search from the head
    // ==============================
    always_comb begin
        int idx;
        mem_req_o  = 1'b0;
        bc_valid_o = 1'b0;
        mem_sel    = '0;
        bc_sel     = '0;
        for (int k = 0; k < LSQ_DEPTH; k++) begin
            idx = int'(head_i) + k;
            if (idx >= LSQ_DEPTH) begin
                idx = idx - LSQ_DEPTH;
            end
            // First hit is the oldest requester
            if (!mem_req_o && ((state_i[idx] == lsq_pkg::RD_MEM) ||
                               (state_i[idx] == lsq_pkg::WR_MEM))) begin
                mem_req_o = 1'b1;
                mem_sel   = IDX_W'(idx);
            end
            if (!bc_valid_o && (state_i[idx] == lsq_pkg::LOAD_CP)) begin
                bc_valid_o = 1'b1;
                bc_sel     = IDX_W'(idx);
            end
        end
    end

    // One-hot grants back to the entries
    always_comb begin
        mem_grant_o         = '0;
        bc_grant_o          = '0;
        mem_grant_o[mem_sel] = mem_req_o;
        bc_grant_o[bc_sel]   = bc_valid_o;
    end

    // Selected entry fields
    assign mem_we_o     = mem_req_o && (cmd_i[mem_sel] == lsq_pkg::STORE);
    assign mem_addr_o   = addr_i[mem_sel];
    assign mem_size_o   = size_i[mem_sel];
    assign mem_wdata_o  = data_i[mem_sel];
    assign bc_tag_o     = tag_i[bc_sel];
    assign bc_rob_idx_o = rob_idx_i[bc_sel];
    assign bc_data_o    = data_i[bc_sel];

endmodule

// File: rtl/lsq_ptrs.sv
// LSQ head and tail pointers
`timescale 1ns/1ps

module lsq_ptrs #(
    parameter int  LSQ_DEPTH = 4,
    localparam int IDX_W     = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1,
    localparam int CNT_W     = $clog2(LSQ_DEPTH + 1)
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 rollback_i,
    input  logic                 dp_valid_i,
    input  logic                 head_retire_i,
    output logic [IDX_W-1:0]     head_o,
    output logic [LSQ_DEPTH-1:0] alloc_o,
    output logic [LSQ_DEPTH-1:0] free_o,
    output logic                 full_o
);

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic             alloc;

    // Circular increment
    function automatic logic [IDX_W-1:0] ptr_inc(logic [IDX_W-1:0] p);
        return (p == IDX_W'(LSQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Dispatch is dropped while full
    assign full_o = (count_q == CNT_W'(LSQ_DEPTH));
    assign alloc  = dp_valid_i && !full_o;

    // One-hot strobes at tail and head
    always_comb begin
        alloc_o         = '0;
        free_o          = '0;
        alloc_o[tail_q] = alloc;
        free_o[head_q]  = head_retire_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (rollback_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) tail_q <= ptr_inc(tail_q);
            if (head_retire_i) head_q <= ptr_inc(head_q);
            count_q <= count_q + CNT_W'(alloc) - CNT_W'(head_retire_i);
        end
    end

    assign head_o = head_q;

endmodule

// File: rtl/lsq_store_scan.sv
// LSQ older store check
`timescale 1ns/1ps

module lsq_store_scan #(
    parameter int  LSQ_DEPTH = 4,
    parameter int  ENTRY_IDX = 0,
    localparam int IDX_W     = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1
) (
    input  logic [IDX_W-1:0]                     head_i,
    // Fields of all entries
    input  lsq_pkg::lsq_cmd_e  [LSQ_DEPTH-1:0]   cmd_i,
    input  logic               [LSQ_DEPTH-1:0]   addr_valid_i,
    input  lsq_pkg::word_t     [LSQ_DEPTH-1:0]   addr_i,
    input  lsq_pkg::mem_size_e [LSQ_DEPTH-1:0]   size_i,
    input  lsq_pkg::word_t     [LSQ_DEPTH-1:0]   data_i,
    // Fields of this entry
    input  lsq_pkg::word_t                       own_addr_i,
    input  lsq_pkg::mem_size_e                   own_size_i,
    // Check result
    output logic                                 older_known_o,
    output logic                                 depend_o,
    output lsq_pkg::word_t                       fwd_data_o
);

    // ==============================
    // Walk from the head to this entry
    // ==============================
    always_comb begin
        int   idx;
        logic reached;
        older_known_o = 1'b1;
        depend_o      = 1'b0;
        fwd_data_o    = '0;
        reached       = 1'b0;
        for (int k = 0; k < LSQ_DEPTH; k++) begin
            // Circular position k steps past the head
            idx = int'(head_i) + k;
            if (idx >= LSQ_DEPTH) begin
                idx = idx - LSQ_DEPTH;
            end
            // Entries from here on are this one or younger
            if (idx == ENTRY_IDX) begin
                reached = 1'b1;
            end
            // Only older stores matter, loads are skipped
            if (!reached && (cmd_i[idx] == lsq_pkg::STORE)) begin
                if (!addr_valid_i[idx]) begin
                    older_known_o = 1'b0;
                end else if ((addr_i[idx] == own_addr_i) && (size_i[idx] == own_size_i)) begin
                    // Later match overrides, so the nearest store wins
                    depend_o   = 1'b1;
                    fwd_data_o = data_i[idx];
                end
            end
        end
    end

endmodule

// File: rtl/lsq_entry.sv
// LSQ entry
`timescale 1ns/1ps

module lsq_entry #(
    parameter int LSQ_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                rollback_i,
    // Strobes from the pointer logic
    input  logic                alloc_i,
    input  logic                free_i,
    // Dispatch fields
    input  lsq_pkg::lsq_cmd_e   dp_cmd_i,
    input  lsq_pkg::mem_size_e  dp_size_i,
    input  logic                dp_sign_i,
    input  lsq_pkg::rob_idx_t   dp_rob_idx_i,
    input  lsq_pkg::tag_t       dp_tag_i,
    // FU result
    input  logic                fu_valid_i,
    input  lsq_pkg::rob_idx_t   fu_rob_idx_i,
    input  lsq_pkg::word_t      fu_addr_i,
    input  lsq_pkg::word_t      fu_data_i,
    // Older store check of this entry
    input  logic                older_known_i,
    input  logic                depend_i,
    input  lsq_pkg::word_t      fwd_data_i,
    // Memory port
    input  logic                mem_grant_i,
    input  logic                mem_ack_i,
    input  lsq_pkg::word_t      mem_rdata_i,
    // Broadcast port
    input  logic                bc_grant_i,
    input  logic                bc_done_i,
    // ROB retire
    input  logic                rt_valid_i,
    input  lsq_pkg::rob_idx_t   rt_rob_idx_i,
    // Entry contents
    output lsq_pkg::lsq_state_e state_o,
    output lsq_pkg::lsq_cmd_e   cmd_o,
    output lsq_pkg::mem_size_e  size_o,
    output lsq_pkg::word_t      addr_o,
    output logic                addr_valid_o,
    output lsq_pkg::word_t      data_o,
    output lsq_pkg::rob_idx_t   rob_idx_o,
    output lsq_pkg::tag_t       tag_o
);

    lsq_pkg::lsq_state_e state_q, state_d;
    lsq_pkg::lsq_cmd_e   cmd_q, cmd_d;
    logic                addr_valid_q, addr_valid_d;
    lsq_pkg::mem_size_e  size_q, size_d;
    logic                sign_q, sign_d;
    lsq_pkg::word_t      addr_q, addr_d;
    lsq_pkg::word_t      data_q, data_d;
    lsq_pkg::rob_idx_t   rob_idx_q, rob_idx_d;
    lsq_pkg::tag_t       tag_q, tag_d;
    logic                fu_hit;
    logic                rt_hit;

    // FU result and ROB retire matched by ROB index
    assign fu_hit = fu_valid_i && (fu_rob_idx_i == rob_idx_q);
    assign rt_hit = rt_valid_i && (rt_rob_idx_i == rob_idx_q);

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_d      = state_q;
        cmd_d        = cmd_q;
        addr_valid_d = addr_valid_q;
        size_d       = size_q;
        sign_d       = sign_q;
        addr_d       = addr_q;
        data_d       = data_q;
        rob_idx_d    = rob_idx_q;
        tag_d        = tag_q;
        case (state_q)
            lsq_pkg::IDLE: begin
                // Allocated at the tail
                if (alloc_i) begin
                    state_d   = lsq_pkg::ADDR;
                    cmd_d     = dp_cmd_i;
                    size_d    = dp_size_i;
                    sign_d    = dp_sign_i;
                    rob_idx_d = dp_rob_idx_i;
                    tag_d     = dp_tag_i;
                end
            end
            lsq_pkg::ADDR: begin
                if (fu_hit) begin
                    addr_d       = fu_addr_i;
                    addr_valid_d = 1'b1;
                    // Store is complete once address and data are known
                    if (cmd_q == lsq_pkg::STORE) begin
                        data_d  = fu_data_i;
                        state_d = lsq_pkg::ROB_RETIRE;
                    end else begin
                        // Load checks older stores against the stored address
                        state_d = lsq_pkg::DEPEND;
                    end
                end
            end
            lsq_pkg::DEPEND: begin
                // Forward from the nearest matching store, else read memory
                if (older_known_i && depend_i) begin
                    data_d  = lsq_pkg::extend_load(fwd_data_i, size_q, sign_q);
                    state_d = lsq_pkg::LOAD_CP;
                end else if (older_known_i) begin
                    state_d = lsq_pkg::RD_MEM;
                end
            end
            lsq_pkg::RD_MEM: begin
                if (mem_grant_i && mem_ack_i) begin
                    data_d  = lsq_pkg::extend_load(mem_rdata_i, size_q, sign_q);
                    state_d = lsq_pkg::LOAD_CP;
                end
            end
            lsq_pkg::LOAD_CP: begin
                if (bc_grant_i && bc_done_i) begin
                    state_d = lsq_pkg::ROB_RETIRE;
                end
            end
            lsq_pkg::ROB_RETIRE: begin
                // Loads are done, stores may now write memory
                if (rt_hit && (cmd_q == lsq_pkg::LOAD)) begin
                    state_d = lsq_pkg::RETIRE;
                end else if (rt_hit) begin
                    state_d = lsq_pkg::WR_MEM;
                end
            end
            lsq_pkg::WR_MEM: begin
                if (mem_grant_i && mem_ack_i) begin
                    state_d = lsq_pkg::RETIRE;
                end
            end
            default: begin
                // RETIRE holds until freed from the head
                state_d = state_q;
            end
        endcase
        // Leaving the queue or rollback empties the slot
        if (free_i || rollback_i) begin
            state_d      = lsq_pkg::IDLE;
            cmd_d        = lsq_pkg::NONE;
            addr_valid_d = 1'b0;
            size_d       = lsq_pkg::BYTE;
            sign_d       = 1'b0;
            addr_d       = '0;
            data_d       = '0;
            rob_idx_d    = '0;
            tag_d        = '0;
        end
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= lsq_pkg::IDLE;
            cmd_q        <= lsq_pkg::NONE;
            addr_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            cmd_q        <= cmd_d;
            addr_valid_q <= addr_valid_d;
        end
    end

    // Payload fields
    always_ff @(posedge clk_i) begin
        size_q    <= size_d;
        sign_q    <= sign_d;
        addr_q    <= addr_d;
        data_q    <= data_d;
        rob_idx_q <= rob_idx_d;
        tag_q     <= tag_d;
    end

    assign state_o      = state_q;
    assign cmd_o        = cmd_q;
    assign size_o       = size_q;
    assign addr_o       = addr_q;
    assign addr_valid_o = addr_valid_q;
    assign data_o       = data_q;
    assign rob_idx_o    = rob_idx_q;
    assign tag_o        = tag_q;

endmodule

// File: rtl/lsq_pkg.sv
// LSQ shared definitions
package lsq_pkg;

    // ==============================
    // Widths
    // ==============================

    // Data and address width
    parameter int XLEN      = 32;
    // ROB index width
    parameter int ROB_IDX_W = 5;
    // Physical destination tag width
    parameter int TAG_W     = 6;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;

    // ==============================
    // Encodings
    // ==============================

    // Memory operation held by an entry
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } lsq_cmd_e;

    // Access size
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // Entry life cycle
    typedef enum logic [2:0] {
        IDLE       = 3'd0,  // Free slot
        ADDR       = 3'd1,  // Waiting for the FU address
        DEPEND     = 3'd2,  // Load waiting on older stores
        RD_MEM     = 3'd3,  // Load reading memory
        LOAD_CP    = 3'd4,  // Load result ready, waiting to broadcast
        ROB_RETIRE = 3'd5,  // Waiting for the ROB
        WR_MEM     = 3'd6,  // Retired store writing memory
        RETIRE     = 3'd7   // Done, waiting to leave from the head
    } lsq_state_e;

    // Sign or zero extension of loaded data by access size
    function automatic word_t extend_load(word_t raw, mem_size_e size, logic sign);
        word_t res;
        case (size)
            BYTE:    res = {{(XLEN-8){sign & raw[7]}}, raw[7:0]};
            HALF:    res = {{(XLEN-16){sign & raw[15]}}, raw[15:0]};
            default: res = raw;
        endcase
        return res;
    endfunction

endpackage
